//--- Makefile
TOP := tb_frontend

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "No errors"

clean:
	rm -rf obj_dir

//--- files.f
source/rv_pkg.sv
source/imm_gen.sv
source/control_unit.sv
source/register_file.sv
source/fetch_unit.sv
source/inst_queue.sv
source/stage_id.sv
source/frontend_top.sv
tb/tb_frontend.sv

//--- source/control_unit.sv
`timescale 1ns/100ps

module control_unit import rv_pkg::*; (
    input  word_t     inst,
    output ex_ctrl_t  ex_ctrl,
    output mem_ctrl_t mem_ctrl,
    output wb_ctrl_t  wb_ctrl,
    output logic      rs1_unused,
    output logic      rs2_unused
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    assign opcode   = opcode_t'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7_5 = inst[30];

    always_comb begin
        ex_ctrl    = '0;
        mem_ctrl   = '0;
        wb_ctrl    = '0;
        rs1_unused = 1'b1;
        rs2_unused = 1'b1;
        case (opcode)
            LOAD: begin
                ex_ctrl.alu_src_imm = 1'b1;
                mem_ctrl.mem_read   = 1'b1;
                mem_ctrl.width      = funct3;
                wb_ctrl.reg_write   = 1'b1;
                wb_ctrl.mem_to_reg  = 1'b1;
                rs1_unused          = 1'b0;
            end
            STORE: begin
                ex_ctrl.alu_src_imm = 1'b1;
                mem_ctrl.mem_write  = 1'b1;
                mem_ctrl.width      = funct3;
                rs1_unused          = 1'b0;
                rs2_unused          = 1'b0;
            end
            OP: begin
                ex_ctrl.alu_op    = {funct7_5, funct3};
                wb_ctrl.reg_write = 1'b1;
                rs1_unused        = 1'b0;
                rs2_unused        = 1'b0;
            end
            OP_IMM: begin
                // only srai carries funct7 meaning.
                ex_ctrl.alu_op      = {funct7_5 && (funct3 == 3'b101), funct3};
                ex_ctrl.alu_src_imm = 1'b1;
                wb_ctrl.reg_write   = 1'b1;
                rs1_unused          = 1'b0;
            end
            // x0 + imm, rs1 is forced to zero upstream.
            LUI: begin
                ex_ctrl.alu_src_imm = 1'b1;
                wb_ctrl.reg_write   = 1'b1;
            end
            AUIPC: begin
                ex_ctrl.alu_src_imm = 1'b1;
                ex_ctrl.alu_src_pc  = 1'b1;
                wb_ctrl.reg_write   = 1'b1;
            end
            BRANCH: begin
                ex_ctrl.alu_op = {1'b0, funct3};
                ex_ctrl.branch = 1'b1;
                rs1_unused     = 1'b0;
                rs2_unused     = 1'b0;
            end
            JAL: begin
                ex_ctrl.alu_src_pc = 1'b1;
                ex_ctrl.jump       = 1'b1;
                wb_ctrl.reg_write  = 1'b1;
            end
            JALR: begin
                ex_ctrl.alu_src_imm = 1'b1;
                ex_ctrl.jump        = 1'b1;
                wb_ctrl.reg_write   = 1'b1;
                rs1_unused          = 1'b0;
            end
            // unknown opcodes keep the all-zero defaults.
            default: ;
        endcase
    end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import rv_pkg::*; #(
    parameter word_t RESET_PC    = '0,
    parameter int    QUEUE_DEPTH = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         redirect,
    input  word_t                        redirect_pc,
    input  logic [$clog2(QUEUE_DEPTH):0] queue_space,
    input  word_t                        wb_dat_i,
    input  logic                         wb_ack,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output word_t                        wb_adr,
    output logic                         push,
    output fetch_entry_t                 push_entry
);

    typedef enum logic {
        FETCH_IDLE,
        FETCH_REQ
    } fetch_state_t;

    fetch_state_t state;
    word_t        pc;
    word_t        req_adr;
    logic         discard;
    logic         start;

    // a new transfer needs a free slot and no pending redirect.
    assign start = (state == FETCH_IDLE) && !redirect && (queue_space != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= FETCH_IDLE;
            pc      <= RESET_PC;
            discard <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (start) begin
                        state <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (wb_ack) begin
                        state   <= FETCH_IDLE;
                        discard <= 1'b0;
                    end else if (redirect) begin
                        discard <= 1'b1;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
            if (redirect) begin
                pc <= {redirect_pc[31:2], 2'b00};
            end else if (push) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // address held stable for the whole transfer.
    always_ff @(posedge clk) begin
        if (start) begin
            req_adr <= pc;
        end
    end

    assign wb_cyc = (state == FETCH_REQ);
    assign wb_stb = (state == FETCH_REQ);
    assign wb_we  = 1'b0;
    assign wb_adr = req_adr;

    // stale words are dropped.
    assign push            = (state == FETCH_REQ) && wb_ack && !discard && !redirect;
    assign push_entry.pc   = req_adr;
    assign push_entry.inst = wb_dat_i;

endmodule

//--- source/frontend_top.sv
`timescale 1ns/100ps

module frontend_top import rv_pkg::*; #(
    parameter word_t RESET_PC    = '0,
    parameter int    QUEUE_DEPTH = 2
) (
    input  logic     clk,
    input  logic     rst,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output word_t    wb_adr,
    input  word_t    wb_dat_i,
    input  logic     wb_ack,
    input  logic     redirect,
    input  word_t    redirect_pc,
    input  reg_idx_t id_ex_rd,
    input  logic     id_ex_mem_read,
    input  logic     wb_reg_write,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output id_ex_t   decoded
);

    logic                         push;
    fetch_entry_t                 push_entry;
    logic                         pop;
    fetch_entry_t                 head;
    logic                         head_valid;
    logic [$clog2(QUEUE_DEPTH):0] free_slots;

    fetch_unit #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) fetch_unit0 (
        .clk,
        .rst,
        .redirect,
        .redirect_pc,
        .queue_space (free_slots),
        .wb_dat_i,
        .wb_ack,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .push,
        .push_entry
    );

    // a redirect empties the queue.
    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) inst_queue0 (
        .clk,
        .rst,
        .flush (redirect),
        .push,
        .push_entry,
        .pop,
        .head,
        .head_valid,
        .free_slots
    );

    stage_id stage_id0 (
        .clk,
        .rst,
        .head,
        .head_valid,
        .redirect,
        .id_ex_rd,
        .id_ex_mem_read,
        .wb_reg_write,
        .wb_rd,
        .wb_data,
        .pop,
        .decoded
    );

endmodule

//--- source/imm_gen.sv
`timescale 1ns/100ps

module imm_gen import rv_pkg::*; (
    input  word_t inst,
    output word_t imm
);

    opcode_t opcode;

    assign opcode = opcode_t'(inst[6:0]);

    always_comb begin
        case (opcode)
            // i format.
            LOAD, OP_IMM, JALR: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            // s format.
            STORE: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            // b format, bit 0 always zero.
            BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            LUI, AUIPC: begin
                imm = {inst[31:12], 12'b0};
            end
            // j format.
            JAL: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            // r type has no immediate.
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- source/inst_queue.sv
`timescale 1ns/100ps

module inst_queue import rv_pkg::*; #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         push,
    input  fetch_entry_t                 push_entry,
    input  logic                         pop,
    output fetch_entry_t                 head,
    output logic                         head_valid,
    output logic [$clog2(QUEUE_DEPTH):0] free_slots
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    fetch_entry_t     slots [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count unchanged.
            count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_entry;
        end
    end

    assign head       = slots[rd_ptr];
    assign head_valid = (count != '0);
    assign free_slots = (PTR_W + 1)'(QUEUE_DEPTH) - count;

endmodule

//--- source/register_file.sv
`timescale 1ns/100ps

module register_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t read_reg_1,
    input  reg_idx_t read_reg_2,
    input  reg_idx_t write_reg,
    input  word_t    write_data,
    input  logic     reg_write,
    output word_t    read_data_1,
    output word_t    read_data_2
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (write_reg != '0)) begin
            regs[write_reg] <= write_data;
        end
    end

    // write-through so decode sees this cycle's writeback.
    assign read_data_1 = (read_reg_1 == '0) ? '0 :
                         (reg_write && (write_reg == read_reg_1)) ? write_data :
                         regs[read_reg_1];
    assign read_data_2 = (read_reg_2 == '0) ? '0 :
                         (reg_write && (write_reg == read_reg_2)) ? write_data :
                         regs[read_reg_2];

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // rv32i major opcodes, inst[6:0].
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    typedef struct packed {
        logic [3:0] alu_op;
        logic       alu_src_imm;
        logic       alu_src_pc;
        logic       branch;
        logic       jump;
    } ex_ctrl_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic [2:0] width;
    } mem_ctrl_t;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } wb_ctrl_t;

    // one queue slot.
    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_entry_t;

    // bundle handed to the id/ex register.
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        word_t     reg_data1;
        word_t     reg_data2;
        word_t     imm;
        ex_ctrl_t  ex_ctrl;
        mem_ctrl_t mem_ctrl;
        wb_ctrl_t  wb_ctrl;
    } id_ex_t;

endpackage

//--- source/stage_id.sv
`timescale 1ns/100ps

module stage_id import rv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  fetch_entry_t head,
    input  logic         head_valid,
    input  logic         redirect,
    input  reg_idx_t     id_ex_rd,
    input  logic         id_ex_mem_read,
    input  logic         wb_reg_write,
    input  reg_idx_t     wb_rd,
    input  word_t        wb_data,
    output logic         pop,
    output id_ex_t       decoded
);

    word_t     inst;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     reg_data1;
    word_t     reg_data2;
    word_t     imm;
    ex_ctrl_t  ex_ctrl;
    mem_ctrl_t mem_ctrl;
    wb_ctrl_t  wb_ctrl;
    logic      rs1_unused;
    logic      rs2_unused;
    logic      stall;
    logic      fire;

    assign inst = head.inst;
    assign rs1  = rs1_unused ? '0 : inst[19:15];
    assign rs2  = inst[24:20];
    assign rd   = inst[11:7];

    // unused rs1 is already zero and never matches a nonzero rd.
    assign stall = head_valid && id_ex_mem_read && (id_ex_rd != '0) &&
                   ((id_ex_rd == rs1) || (!rs2_unused && (id_ex_rd == rs2)));
    assign fire  = head_valid && !stall && !redirect;
    assign pop   = fire;

    imm_gen imm_gen0 (
        .inst,
        .imm
    );

    control_unit control_unit0 (
        .inst,
        .ex_ctrl,
        .mem_ctrl,
        .wb_ctrl,
        .rs1_unused,
        .rs2_unused
    );

    register_file register_file0 (
        .clk,
        .rst,
        .read_reg_1  (rs1),
        .read_reg_2  (rs2),
        .write_reg   (wb_rd),
        .write_data  (wb_data),
        .reg_write   (wb_reg_write),
        .read_data_1 (reg_data1),
        .read_data_2 (reg_data2)
    );

    // bubble when not issuing.
    always_comb begin
        decoded.valid     = fire;
        decoded.pc        = head.pc;
        decoded.rs1       = rs1;
        decoded.rs2       = rs2;
        decoded.rd        = rd;
        decoded.reg_data1 = reg_data1;
        decoded.reg_data2 = reg_data2;
        decoded.imm       = imm;
        decoded.ex_ctrl   = fire ? ex_ctrl : '0;
        decoded.mem_ctrl  = fire ? mem_ctrl : '0;
        decoded.wb_ctrl   = fire ? wb_ctrl : '0;
    end

endmodule

//--- tb/tb_frontend.sv
`timescale 1ns/100ps

module tb_frontend import rv_pkg::*; ();

    localparam word_t RESET_PC    = '0;
    localparam int    NUM_INSTS   = 300;
    // 300 instructions at up to 6 cycles each, with margin.
    localparam int    CYCLE_LIMIT = 4000;
    localparam int    MEM_WORDS   = 1024;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    word_t    wb_adr;
    word_t    wb_dat_i = '0;
    logic     wb_ack = 1'b0;
    logic     redirect = 1'b0;
    word_t    redirect_pc = '0;
    reg_idx_t id_ex_rd = '0;
    logic     id_ex_mem_read = 1'b0;
    logic     wb_reg_write = 1'b0;
    reg_idx_t wb_rd = '0;
    word_t    wb_data = '0;
    id_ex_t   decoded;

    word_t       imem [MEM_WORDS];
    word_t       shadow [32];
    logic [31:0] lfsr = 32'h09e1_37b4;
    logic [1:0]  ack_wait = '0;
    word_t       exp_pc = '0;
    logic        prev_stb = 1'b0;
    logic        prev_ack = 1'b0;
    word_t       prev_adr = '0;
    int          cycles = 0;
    int          issued = 0;
    word_t       head_word;

    always #2 clk = ~clk;

    frontend_top dut0 (
        .clk,
        .rst,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_i,
        .wb_ack,
        .redirect,
        .redirect_pc,
        .id_ex_rd,
        .id_ex_mem_read,
        .wb_reg_write,
        .wb_rd,
        .wb_data,
        .decoded
    );

    // memory word expected at the queue head.
    assign head_word = imem[exp_pc[11:2]];

    // fibonacci lfsr, taps 32 22 2 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic abort_run(string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic value_error(string test, word_t expected, word_t actual);
        abort_run($sformatf("ERR %s: expected %h, actual %h", test, expected, actual));
    endtask

    function automatic word_t expected_imm(word_t w);
        word_t sx;
        sx = {32{w[31]}};
        case (w[6:0])
            LOAD, OP_IMM: return {sx[31:12], w[31:20]};
            STORE:        return {sx[31:12], w[31:25], w[11:7]};
            BRANCH:       return {sx[31:13], w[31], w[7], w[30:25], w[11:8], 1'b0};
            LUI:          return {w[31:12], 12'h000};
            JAL:          return {sx[31:21], w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:      return '0;
        endcase
    endfunction

    // lui and jal read no rs1.
    function automatic reg_idx_t expected_rs1(word_t w);
        if (w[6:0] == LUI || w[6:0] == JAL) begin
            return '0;
        end
        return w[19:15];
    endfunction

    // i, s and u formats take the immediate, jal takes the pc.
    function automatic logic [1:0] expected_src(word_t w);
        case (w[6:0])
            LOAD, STORE, OP_IMM, LUI: return 2'b10;
            JAL:                      return 2'b01;
            default:                  return 2'b00;
        endcase
    endfunction

    function automatic word_t expected_read(reg_idx_t r);
        if (r == '0) begin
            return '0;
        end
        if (wb_reg_write && wb_rd == r) begin
            return wb_data;
        end
        return shadow[r];
    endfunction

    function automatic logic hazard_expected(word_t w, reg_idx_t rd, logic mem_read);
        logic rs1_used;
        logic rs2_used;
        rs1_used = !(w[6:0] == LUI || w[6:0] == JAL);
        rs2_used = (w[6:0] == STORE) || (w[6:0] == OP) || (w[6:0] == BRANCH);
        return mem_read && (rd != '0) &&
               ((rs1_used && rd == w[19:15]) || (rs2_used && rd == w[24:20]));
    endfunction

    task automatic build_program();
        logic [2:0] pick;
        opcode_t    op;
        for (int i = 0; i < MEM_WORDS; i++) begin
            pick = 3'(random_bits(3));
            case (pick)
                3'd0:    op = LOAD;
                3'd1:    op = STORE;
                3'd2:    op = OP_IMM;
                3'd3:    op = LUI;
                3'd4:    op = BRANCH;
                3'd5:    op = JAL;
                default: op = OP;
            endcase
            imem[i] = {25'(random_bits(25)), op};
        end
    endtask

    initial begin : stimulus
        logic [1:0] sel;
        build_program();
        forever begin
            @(posedge clk);
            if (rst) begin
                wb_ack         <= 1'b0;
                ack_wait       <= 2'(random_bits(2));
                redirect       <= 1'b0;
                id_ex_mem_read <= 1'b0;
                wb_reg_write   <= 1'b0;
            end else begin
                // wishbone slave, 0 to 3 wait cycles.
                if (wb_ack) begin
                    wb_ack   <= 1'b0;
                    ack_wait <= 2'(random_bits(2));
                end else if (wb_stb) begin
                    if (ack_wait == '0) begin
                        wb_ack   <= 1'b1;
                        wb_dat_i <= imem[wb_adr[11:2]];
                    end else begin
                        ack_wait <= ack_wait - 2'd1;
                    end
                end
                // aim the load in ex at the head's sources now and then.
                sel = 2'(random_bits(2));
                id_ex_mem_read <= (sel != 2'd3);
                case (sel)
                    2'd0:    id_ex_rd <= decoded.rs1;
                    2'd1:    id_ex_rd <= decoded.rs2;
                    default: id_ex_rd <= 5'(random_bits(5));
                endcase
                wb_reg_write <= 1'(random_bits(1));
                if (random_bits(1) == 32'd1) begin
                    wb_rd <= decoded.rs1;
                end else begin
                    wb_rd <= 5'(random_bits(5));
                end
                wb_data     <= random_bits(32);
                redirect    <= (random_bits(6) == 32'd0);
                redirect_pc <= {20'd0, 10'(random_bits(10)), 2'b00};
            end
        end
    end

    // reference state.
    always @(posedge clk) begin
        prev_stb <= wb_stb;
        prev_ack <= wb_ack;
        prev_adr <= wb_adr;
        if (rst) begin
            exp_pc <= RESET_PC;
            cycles <= 0;
            issued <= 0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            cycles <= cycles + 1;
            if (redirect) begin
                exp_pc <= redirect_pc;
            end else if (decoded.valid) begin
                exp_pc <= exp_pc + 32'd4;
                issued <= issued + 1;
            end
            if (wb_reg_write && wb_rd != '0) begin
                shadow[wb_rd] <= wb_data;
            end
        end
    end

    pc_order: assert property (@(negedge clk) disable iff (rst)
        decoded.valid |-> decoded.pc == exp_pc)
        else value_error("pc order", exp_pc, decoded.pc);
    rs1_field: assert property (@(negedge clk) disable iff (rst)
        decoded.valid |-> decoded.rs1 == expected_rs1(head_word))
        else value_error("rs1 field", 32'(expected_rs1(head_word)), 32'(decoded.rs1));
    rs2_field: assert property (@(negedge clk) disable iff (rst)
        decoded.valid |-> decoded.rs2 == head_word[24:20])
        else value_error("rs2 field", 32'(head_word[24:20]), 32'(decoded.rs2));
    rd_field: assert property (@(negedge clk) disable iff (rst)
        decoded.valid |-> decoded.rd == head_word[11:7])
        else value_error("rd field", 32'(head_word[11:7]), 32'(decoded.rd));
    imm_field: assert property (@(negedge clk) disable iff (rst)
        decoded.valid |-> decoded.imm == expected_imm(head_word))
        else value_error("immediate", expected_imm(head_word), decoded.imm);

    read_port1: assert property (@(negedge clk) disable iff (rst)
        decoded.valid |-> decoded.reg_data1 == expected_read(decoded.rs1))
        else value_error("read data 1", expected_read(decoded.rs1), decoded.reg_data1);
    read_port2: assert property (@(negedge clk) disable iff (rst)
        decoded.valid |-> decoded.reg_data2 == expected_read(decoded.rs2))
        else value_error("read data 2", expected_read(decoded.rs2), decoded.reg_data2);

    load_use_stall: assert property (@(negedge clk) disable iff (rst)
        hazard_expected(head_word, id_ex_rd, id_ex_mem_read) |-> !decoded.valid)
        else abort_run("load-use hazard went through without a stall");
    bubble_ctrl: assert property (@(negedge clk) disable iff (rst)
        !decoded.valid |-> {decoded.ex_ctrl, decoded.mem_ctrl, decoded.wb_ctrl} == '0)
        else value_error("bubble controls", '0,
                         32'({decoded.ex_ctrl, decoded.mem_ctrl, decoded.wb_ctrl}));
    redirect_hold: assert property (@(negedge clk) disable iff (rst)
        redirect |-> !decoded.valid)
        else abort_run("an instruction was issued in a redirect cycle");

    load_ctrl: assert property (@(negedge clk) disable iff (rst)
        (decoded.valid && head_word[6:0] == LOAD) |->
        {decoded.mem_ctrl.mem_read, decoded.wb_ctrl.reg_write,
         decoded.wb_ctrl.mem_to_reg} == 3'b111)
        else value_error("load control", 32'h7, 32'({decoded.mem_ctrl.mem_read,
                         decoded.wb_ctrl.reg_write, decoded.wb_ctrl.mem_to_reg}));
    store_ctrl: assert property (@(negedge clk) disable iff (rst)
        (decoded.valid && head_word[6:0] == STORE) |->
        {decoded.mem_ctrl.mem_write, decoded.wb_ctrl.reg_write} == 2'b10)
        else value_error("store control", 32'h2,
                         32'({decoded.mem_ctrl.mem_write, decoded.wb_ctrl.reg_write}));
    mem_width: assert property (@(negedge clk) disable iff (rst)
        (decoded.valid && (head_word[6:0] == LOAD || head_word[6:0] == STORE)) |->
        decoded.mem_ctrl.width == head_word[14:12])
        else value_error("memory width", 32'(head_word[14:12]),
                         32'(decoded.mem_ctrl.width));
    operand_src: assert property (@(negedge clk) disable iff (rst)
        decoded.valid |->
        {decoded.ex_ctrl.alu_src_imm, decoded.ex_ctrl.alu_src_pc} == expected_src(head_word))
        else value_error("operand source", 32'(expected_src(head_word)),
                         32'({decoded.ex_ctrl.alu_src_imm, decoded.ex_ctrl.alu_src_pc}));
    branch_ctrl: assert property (@(negedge clk) disable iff (rst)
        (decoded.valid && head_word[6:0] == BRANCH) |-> decoded.ex_ctrl.branch)
        else value_error("branch control", 32'h1, 32'(decoded.ex_ctrl.branch));
    jal_ctrl: assert property (@(negedge clk) disable iff (rst)
        (decoded.valid && head_word[6:0] == JAL) |->
        {decoded.ex_ctrl.jump, decoded.wb_ctrl.reg_write} == 2'b11)
        else value_error("jal control", 32'h3,
                         32'({decoded.ex_ctrl.jump, decoded.wb_ctrl.reg_write}));

    stb_in_cyc: assert property (@(negedge clk) disable iff (rst)
        wb_stb |-> wb_cyc)
        else abort_run("wishbone stb was high without cyc");
    no_write: assert property (@(negedge clk) disable iff (rst)
        !wb_we)
        else abort_run("wishbone we was high on the fetch port");
    adr_aligned: assert property (@(negedge clk) disable iff (rst)
        wb_cyc |-> wb_adr[1:0] == 2'b00)
        else value_error("address alignment", 32'h0, 32'(wb_adr[1:0]));
    req_stable: assert property (@(negedge clk) disable iff (rst)
        (prev_stb && !prev_ack) |-> (wb_stb && wb_adr == prev_adr))
        else abort_run("wishbone address or strobe changed before ack");

    initial begin
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (issued < NUM_INSTS && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        if (issued < NUM_INSTS) begin
            abort_run($sformatf("timeout, the program did not complete: %0d of %0d decoded",
                                issued, NUM_INSTS));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule
